// ==== flist.f ====
source/branch_pkg.sv
source/branch_if.sv
source/vector_sr.sv
source/op_decode.sv
source/flag_gen.sv
source/cond_test.sv
source/jmp_target.sv
source/pc_next.sv
source/branch_unit_top.sv
sim/branch_unit_assert.sv
sim/tb_branch_unit.sv

// ==== run.sh ====
#!/bin/bash
# build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_branch_unit \
	-o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
grep -q "^Testbench passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim/tb_branch_unit.sv ====
module tb_branch_unit;

	localparam int DATA_W  = branch_pkg::DATA_W;
	localparam int PC_W    = branch_pkg::PC_W;
	localparam int IMM_W   = branch_pkg::IMM_W;
	localparam int LAT     = branch_pkg::latency(1, 1);
	localparam int N_RAND  = 400;	// random vectors
	localparam int N_DIR   = 40;	// 8 opcodes x 5 directed
	localparam int TIMEOUT = (N_RAND + N_DIR + 20) * 10 + 500;

	logic              clk_i;
	logic              rst_i;
	logic              valid_i;
	branch_pkg::op_e   op_i;
	logic [PC_W-1:0]   pc_i;
	logic [DATA_W-1:0] a_i;
	logic [DATA_W-1:0] b_i;
	logic [IMM_W-1:0]  imm_i;
	logic              valid_o;
	logic              taken_o;
	logic [PC_W-1:0]   pc_o;
	logic [31:0]       lfsr = 32'he5e29cdb;
	int                n_vec = 0;
	int                n_err;

	branch_unit_top DUT (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.valid_i (valid_i),
		.op_i    (op_i),
		.pc_i    (pc_i),
		.a_i     (a_i),
		.b_i     (b_i),
		.imm_i   (imm_i),
		.valid_o (valid_o),
		.taken_o (taken_o),
		.pc_o    (pc_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	// one instruction slot on the falling edge, pc and imm random
	task automatic send(input logic v, input branch_pkg::op_e op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b);
		@(negedge clk_i);
		valid_i = v;
		op_i    = op;
		a_i     = a;
		b_i     = b;
		pc_i    = PC_W'(rand_bits(PC_W));
		imm_i   = IMM_W'(rand_bits(IMM_W));
		n_vec++;
	endtask

	initial begin
		logic [31:0]     x, y;
		branch_pkg::op_e op;
		rst_i   = 1'b1;
		valid_i = 1'b0;
		op_i    = branch_pkg::op_nop;
		pc_i    = '0;
		a_i     = '0;
		b_i     = '0;
		imm_i   = '0;
		repeat (2) @(negedge clk_i);
		rst_i = 1'b0;
		repeat (4) send(1'b0, branch_pkg::op_nop, '0, '0);	// idle after reset
		for (int i = 0; i < N_RAND; i++) begin
			send(rand_bits(2) != 0, branch_pkg::op_e'(3'(rand_bits(3))), rand_bits(32),
				rand_bits(32));	// about 3 in 4 valid
		end
		for (int k = 0; k < 8; k++) begin
			op = branch_pkg::op_e'(3'(k));
			x  = rand_bits(32);
			y  = rand_bits(32);
			send(1'b1, op, '0, x);	// a zero
			send(1'b1, op, x, x);	// a equal b
			send(1'b1, op, {1'b1, x[30:0]}, {1'b0, y[30:0]});	// opposite signs
			send(1'b1, op, {1'b0, x[30:0]}, {1'b1, y[30:0]});
			send(1'b0, op, x, y);	// bubble
		end
		repeat (LAT + 2) send(1'b0, branch_pkg::op_nop, '0, '0);	// drain
		n_err = DUT.u_assert.err_cnt;
		$display("vectors %0d, assertion errors %0d", n_vec, n_err);
		if (n_err == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT);
		$display("timeout: stimulus did not finish in %0d time units", TIMEOUT);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== sim/branch_unit_assert.sv ====
// checker bound into branch_unit_top, compares outputs with inputs from LAT cycles back
module branch_unit_assert #(
	parameter int DATA_W = 32,
	parameter int PC_W   = 16,
	parameter int IMM_W  = 12,
	parameter int LAT    = 2	// total pipeline depth
) (
	input logic              clk_i,
	input logic              rst_i,
	input logic              valid_i,
	input branch_pkg::op_e   op_i,
	input logic [PC_W-1:0]   pc_i,
	input logic [DATA_W-1:0] a_i,
	input logic [DATA_W-1:0] b_i,
	input logic [IMM_W-1:0]  imm_i,
	input logic              valid_o,
	input logic              taken_o,
	input logic [PC_W-1:0]   pc_o
);

	int err_cnt = 0;	// read by the testbench

	// jump condition per opcode
	function automatic logic cond(input branch_pkg::op_e op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b);
		case (op)
			branch_pkg::op_jmp, branch_pkg::op_jabs: return 1'b1;
			branch_pkg::op_jz:   return a == '0;
			branch_pkg::op_jnz:  return a != '0;
			branch_pkg::op_jlt:  return $signed(a) < $signed(b);
			branch_pkg::op_jltu: return a < b;	// plain unsigned compare
			branch_pkg::op_jge:  return $signed(a) >= $signed(b);
			default:             return 1'b0;	// nop
		endcase
	endfunction

	// next pc, taken or fall-through
	function automatic logic [PC_W-1:0] exp_pc(input logic tk, input branch_pkg::op_e op,
		input logic [PC_W-1:0] pc, input logic [DATA_W-1:0] b, input logic [IMM_W-1:0] imm);
		if (!tk)
			return pc + PC_W'(1);
		if (op == branch_pkg::op_jabs)
			return b[PC_W-1:0];
		return pc + PC_W'($signed(imm));	// signed offset, wraps
	endfunction

	a_valid: assert property (@(posedge clk_i) disable iff (rst_i)
		valid_o == $past(valid_i, LAT))
		else begin
			$error("** Error %0t: valid_o does not follow valid_i", $time);
			err_cnt++;
		end

	a_taken: assert property (@(posedge clk_i) disable iff (rst_i)
		taken_o == ($past(valid_i, LAT) &&
			cond($past(op_i, LAT), $past(a_i, LAT), $past(b_i, LAT))))
		else begin
			$error("** Error %0t: taken_o wrong", $time);
			err_cnt++;
		end

	a_pc: assert property (@(posedge clk_i) disable iff (rst_i)
		valid_o |-> pc_o == exp_pc(cond($past(op_i, LAT), $past(a_i, LAT), $past(b_i, LAT)),
			$past(op_i, LAT), $past(pc_i, LAT), $past(b_i, LAT), $past(imm_i, LAT)))
		else begin
			$error("** Error %0t: pc_o wrong", $time);
			err_cnt++;
		end

	// idle slot, nothing taken and pc cleared
	a_idle: assert property (@(posedge clk_i) disable iff (rst_i)
		!valid_o |-> (!taken_o && pc_o == '0))
		else begin
			$error("** Error %0t: idle output not cleared", $time);
			err_cnt++;
		end

endmodule

bind branch_unit_top branch_unit_assert #(
	.DATA_W (DATA_W),
	.PC_W   (PC_W),
	.IMM_W  (IMM_W),
	.LAT    (branch_pkg::latency(REGS_TST, REGS_OUT))
) u_assert (
	.clk_i   (clk_i),
	.rst_i   (rst_i),
	.valid_i (valid_i),
	.op_i    (op_i),
	.pc_i    (pc_i),
	.a_i     (a_i),
	.b_i     (b_i),
	.imm_i   (imm_i),
	.valid_o (valid_o),
	.taken_o (taken_o),
	.pc_o    (pc_o)
);

// ==== source/branch_unit_top.sv ====
module branch_unit_top #(
	parameter int DATA_W   = branch_pkg::DATA_W,
	parameter int PC_W     = branch_pkg::PC_W,
	parameter int IMM_W    = branch_pkg::IMM_W,
	parameter int REGS_TST = 1,	// test input stages
	parameter int REGS_OUT = 1	// result stages
) (
	input  logic              clk_i,
	input  logic              rst_i,	// sync, active high
	input  logic              valid_i,
	input  branch_pkg::op_e   op_i,
	input  logic [PC_W-1:0]   pc_i,
	input  logic [DATA_W-1:0] a_i,
	input  logic [DATA_W-1:0] b_i,
	input  logic [IMM_W-1:0]  imm_i,
	output logic              valid_o,
	output logic              taken_o,
	output logic [PC_W-1:0]   pc_o
);

	test_if tst_bus ();
	flag_if flg_bus ();

	logic            jmp_en, abs_en;
	logic            tst;
	logic [PC_W-1:0] target;

	op_decode u_op_decode (
		.op_i     (op_i),
		.tst_if   (tst_bus.src),
		.jmp_en_o (jmp_en),
		.abs_en_o (abs_en)
	);

	flag_gen #(
		.DATA_W (DATA_W)
	) u_flag_gen (
		.a_i    (a_i),
		.b_i    (b_i),
		.tst_if (tst_bus.dst),
		.flg_if (flg_bus.src)
	);

	// condition path
	cond_test #(
		.REGS_TST (REGS_TST),
		.REGS_OUT (REGS_OUT)
	) u_cond_test (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.tst_if (tst_bus.dst),
		.flg_if (flg_bus.dst),
		.tst_o  (tst)
	);

	// address path, same depth
	jmp_target #(
		.DATA_W   (DATA_W),
		.PC_W     (PC_W),
		.IMM_W    (IMM_W),
		.REGS_TST (REGS_TST),
		.REGS_OUT (REGS_OUT)
	) u_jmp_target (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.pc_i     (pc_i),
		.imm_i    (imm_i),
		.b_i      (b_i),
		.abs_en_i (abs_en),
		.target_o (target)
	);

	pc_next #(
		.PC_W     (PC_W),
		.REGS_TST (REGS_TST),
		.REGS_OUT (REGS_OUT)
	) u_pc_next (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.valid_i  (valid_i),
		.pc_i     (pc_i),
		.jmp_en_i (jmp_en),
		.tst_i    (tst),
		.target_i (target),
		.valid_o  (valid_o),
		.taken_o  (taken_o),
		.pc_o     (pc_o)
	);

endmodule

// ==== source/pc_next.sv ====
module pc_next #(
	parameter int PC_W     = branch_pkg::PC_W,
	parameter int REGS_TST = 1,
	parameter int REGS_OUT = 1
) (
	input  logic            clk_i,
	input  logic            rst_i,
	input  logic            valid_i,
	input  logic [PC_W-1:0] pc_i,
	input  logic            jmp_en_i,	// undelayed, from decode
	input  logic            tst_i,	// already delayed
	input  logic [PC_W-1:0] target_i,	// already delayed
	output logic            valid_o,
	output logic            taken_o,
	output logic [PC_W-1:0] pc_o
);

	logic [PC_W-1:0] pc_inc;	// fall-through, zero when idle
	logic [PC_W-1:0] pc_inc_d;
	logic            valid_d, jmp_en_d;

	assign pc_inc = valid_i ? pc_i + 1'b1 : '0;

	vector_sr #(
		.REGS      (branch_pkg::latency(REGS_TST, REGS_OUT)),
		.DATA_W    (PC_W + 2),
		.RESET_VAL ('0)
	) seq_regs (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i ({valid_i, jmp_en_i, pc_inc}),
		.data_o ({valid_d, jmp_en_d, pc_inc_d})
	);

	assign valid_o = valid_d;
	assign taken_o = valid_d & jmp_en_d & tst_i;	// nop can never jump
	assign pc_o    = taken_o ? target_i : pc_inc_d;

endmodule

// ==== source/jmp_target.sv ====
module jmp_target #(
	parameter int DATA_W   = branch_pkg::DATA_W,
	parameter int PC_W     = branch_pkg::PC_W,
	parameter int IMM_W    = branch_pkg::IMM_W,
	parameter int REGS_TST = 1,
	parameter int REGS_OUT = 1
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic [PC_W-1:0]   pc_i,
	input  logic [IMM_W-1:0]  imm_i,	// signed offset
	input  logic [DATA_W-1:0] b_i,
	input  logic              abs_en_i,	// 1=take b, 0=pc relative
	output logic [PC_W-1:0]   target_o	// aligned with cond_test result
);

	logic [PC_W-1:0] imm_ext;
	logic [PC_W-1:0] target;

	assign imm_ext = {{(PC_W-IMM_W){imm_i[IMM_W-1]}}, imm_i};	// sign extend
	assign target  = abs_en_i ? b_i[PC_W-1:0] : pc_i + imm_ext;	// wraps mod 2**PC_W

	// match the whole condition path depth
	vector_sr #(
		.REGS      (branch_pkg::latency(REGS_TST, REGS_OUT)),
		.DATA_W    (PC_W),
		.RESET_VAL ('0)
	) tgt_regs (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (target),
		.data_o (target_o)
	);

endmodule

// ==== source/cond_test.sv ====
module cond_test #(
	parameter int REGS_TST = 1,	// stages on test and flag inputs
	parameter int REGS_OUT = 1	// stages on result
) (
	input  logic clk_i,
	input  logic rst_i,	// sync, active high
	test_if.dst  tst_if,
	flag_if.dst  flg_if,
	output logic tst_o	// 1=true, 0=false
);

	logic       tst_ab, tst_gt, tst_lt, tst_eq;	// after input regs
	logic       nez, ne, ltz, lt;
	logic       eqz, gtz;	// a vs zero
	logic       eq, gt;	// a vs b
	logic [2:0] t_cat, az_cat, ab_cat;
	logic       res_az, res_ab, tst;

	// flags come straight from the operands, so they ride
	// along with the test bits to stay on the same instruction
	vector_sr #(
		.REGS      (REGS_TST),
		.DATA_W    (8),
		.RESET_VAL (8'd0)
	) tst_regs (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i ({tst_if.tst_ab, tst_if.tst_gt, tst_if.tst_lt, tst_if.tst_eq,
			flg_if.nez, flg_if.ne, flg_if.ltz, flg_if.lt}),
		.data_o ({tst_ab, tst_gt, tst_lt, tst_eq, nez, ne, ltz, lt})
	);

	assign t_cat = {tst_gt, tst_lt, tst_eq};

	// a/zero pair
	assign eqz    = ~nez;
	assign gtz    = ~(ltz | eqz);
	assign az_cat = {gtz, ltz, eqz};
	assign res_az = |(t_cat & az_cat);	// mask then or-reduce

	// a/b pair
	assign eq     = ~ne;
	assign gt     = ~(lt | eq);
	assign ab_cat = {gt, lt, eq};
	assign res_ab = |(t_cat & ab_cat);

	assign tst = tst_ab ? res_ab : res_az;	// pick pair

	vector_sr #(
		.REGS      (REGS_OUT),
		.DATA_W    (1),
		.RESET_VAL (1'b0)
	) out_regs (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (tst),
		.data_o (tst_o)
	);

endmodule

// ==== source/flag_gen.sv ====
module flag_gen #(
	parameter int DATA_W = branch_pkg::DATA_W
) (
	input  logic [DATA_W-1:0] a_i,
	input  logic [DATA_W-1:0] b_i,
	test_if.dst               tst_if,	// only tst_uns read here
	flag_if.src               flg_if
);

	logic lt_s;	// signed a < b
	logic lt_u;	// unsigned a < b

	assign lt_s = $signed(a_i) < $signed(b_i);
	assign lt_u = a_i < b_i;

	// all combinational, cond_test does the registering
	assign flg_if.nez = |a_i;
	assign flg_if.ne  = (a_i != b_i);
	assign flg_if.ltz = a_i[DATA_W-1];	// sign bit
	assign flg_if.lt  = tst_if.tst_uns ? lt_u : lt_s;

endmodule

// ==== source/op_decode.sv ====
module op_decode (
	input  branch_pkg::op_e op_i,
	test_if.src             tst_if,	// test bits out
	output logic            jmp_en_o,	// opcode can jump at all
	output logic            abs_en_o	// target comes from b
);

	always_comb begin
		// defaults: no test, a/zero pair, signed
		tst_if.tst_gt  = 1'b0;
		tst_if.tst_lt  = 1'b0;
		tst_if.tst_eq  = 1'b0;
		tst_if.tst_ab  = 1'b0;
		tst_if.tst_uns = 1'b0;
		jmp_en_o       = 1'b1;
		abs_en_o       = 1'b0;
		case (op_i)
			branch_pkg::op_nop: begin
				jmp_en_o = 1'b0;	// all tests off too
			end
			branch_pkg::op_jmp, branch_pkg::op_jabs: begin
				tst_if.tst_gt = 1'b1;	// >, <, = covers everything
				tst_if.tst_lt = 1'b1;
				tst_if.tst_eq = 1'b1;
				abs_en_o      = (op_i == branch_pkg::op_jabs);
			end
			branch_pkg::op_jz: begin
				tst_if.tst_eq = 1'b1;	// a == 0
			end
			branch_pkg::op_jnz: begin
				tst_if.tst_gt = 1'b1;	// a > 0 or a < 0
				tst_if.tst_lt = 1'b1;
			end
			branch_pkg::op_jlt, branch_pkg::op_jltu: begin
				tst_if.tst_lt  = 1'b1;
				tst_if.tst_ab  = 1'b1;
				tst_if.tst_uns = (op_i == branch_pkg::op_jltu);
			end
			branch_pkg::op_jge: begin
				tst_if.tst_gt = 1'b1;	// > or =
				tst_if.tst_eq = 1'b1;
				tst_if.tst_ab = 1'b1;
			end
			default: jmp_en_o = 1'b0;
		endcase
	end

endmodule

// ==== source/vector_sr.sv ====
module vector_sr #(
	parameter int                REGS      = 1,	// stages, 0 = straight wire
	parameter int                DATA_W    = 8,
	parameter logic [DATA_W-1:0] RESET_VAL = '0
) (
	input  logic              clk_i,
	input  logic              rst_i,	// sync, active high
	input  logic [DATA_W-1:0] data_i,
	output logic [DATA_W-1:0] data_o
);

	generate
		if (REGS == 0) begin : g_wire
			assign data_o = data_i;	// no delay
		end else begin : g_regs
			logic [DATA_W-1:0] stage [REGS];	// stage 0 nearest input

			always_ff @(posedge clk_i) begin
				if (rst_i) begin
					for (int i = 0; i < REGS; i++) begin
						stage[i] <= RESET_VAL;
					end
				end else begin
					stage[0] <= data_i;
					for (int i = 1; i < REGS; i++) begin
						stage[i] <= stage[i-1];	// shift along
					end
				end
			end

			assign data_o = stage[REGS-1];
		end
	endgenerate

endmodule

// ==== source/branch_if.sv ====
// comparison flags, flag_gen -> cond_test
interface flag_if;
	logic nez;	// a != 0
	logic ne;	// a != b
	logic ltz;	// a < 0
	logic lt;	// a < b, signed or unsigned

	modport src (output nez, ne, ltz, lt);
	modport dst (input nez, ne, ltz, lt);
endinterface

// decoded test bits, op_decode -> cond_test / flag_gen
interface test_if;
	logic tst_gt;	// > test
	logic tst_lt;	// < test
	logic tst_eq;	// = test
	logic tst_ab;	// 1=a/b pair, 0=a/zero pair
	logic tst_uns;	// unsigned a/b compare

	modport src (output tst_gt, tst_lt, tst_eq, tst_ab, tst_uns);
	modport dst (input tst_gt, tst_lt, tst_eq, tst_ab, tst_uns);
endinterface

// ==== source/branch_pkg.sv ====
package branch_pkg;

	localparam int DATA_W = 32;	// operand width, a and b
	localparam int PC_W   = 16;	// program counter width
	localparam int IMM_W  = 12;	// signed jump offset width

	// conditional jump opcodes
	typedef enum logic [2:0] {
		op_nop  = 3'd0,	// never taken
		op_jmp  = 3'd1,	// always, relative
		op_jz   = 3'd2,	// a == 0
		op_jnz  = 3'd3,	// a != 0
		op_jlt  = 3'd4,	// a < b signed
		op_jltu = 3'd5,	// a < b unsigned
		op_jge  = 3'd6,	// a >= b signed
		op_jabs = 3'd7	// always, target = b
	} op_e;

	// cycles from instruction in to result out
	function automatic int latency(input int regs_tst, input int regs_out);
		return regs_tst + regs_out;
	endfunction

endpackage
